// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= convAccelTb
RTL_TOP    ?= convAccelTop
FILELIST   ?= vlog.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= === FAIL ===
VFLAGS     ?= --binary --timing -j 0 -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then echo "Simulator exited with status $$status"; exit 1; fi
	@if grep -q -- "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)
	$(VERILATOR) $(LINT_FLAGS) rtl/convDataPkg.sv rtl/convCtrlPkg.sv rtl/operandStore.sv \
		rtl/convSequencer.sv rtl/macUnit.sv rtl/resultFifo.sv rtl/convAccelTop.sv \
		--top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== rtl/convAccelTop.sv ====
`default_nettype none

module convAccelTop
    import convDataPkg::*, convCtrlPkg::*;
#(
    parameter int addrWidth = 10,
    parameter int fifoDepth = 16
) (
    input  logic               clkIn,
    input  logic               rstIn,
    input  logic               wrEnIn,
    input  logic [addrWidth:0] addrIn,
    input  elemT               wrDataIn,
    input  logic               startIn,
    input  dimT                filtRowsIn,
    input  dimT                filtColsIn,
    input  dimT                dataRowsIn,
    input  dimT                dataColsIn,
    output accT                dataOut,
    output logic               validOut,
    input  logic               readyIn
);

    logic [addrWidth-1:0] dataRdAddr;
    logic [addrWidth-1:0] filtRdAddr;
    logic                 prodValid;
    logic                 prodLast;
    elemT                 dataRdElem;
    elemT                 filtRdElem;
    accT                  sumOut;
    logic                 sumValid;
    logic                 fifoRoom;

    operandStore #(
        .addrWidth(addrWidth)
    ) u_operandStore (
        .clkIn      (clkIn),
        .wrEnIn     (wrEnIn),
        .addrIn     (addrIn),
        .wrDataIn   (wrDataIn),
        .dataRdAddr (dataRdAddr),
        .filtRdAddr (filtRdAddr),
        .dataRdElem (dataRdElem),
        .filtRdElem (filtRdElem)
    );

    convSequencer #(
        .addrWidth(addrWidth)
    ) u_convSequencer (
        .clkIn      (clkIn),
        .rstIn      (rstIn),
        .startIn    (startIn),
        .filtRowsIn (filtRowsIn),
        .filtColsIn (filtColsIn),
        .dataRowsIn (dataRowsIn),
        .dataColsIn (dataColsIn),
        .fifoRoom   (fifoRoom),
        .dataRdAddr (dataRdAddr),
        .filtRdAddr (filtRdAddr),
        .prodValid  (prodValid),
        .prodLast   (prodLast)
    );

    macUnit u_macUnit (
        .clkIn      (clkIn),
        .rstIn      (rstIn),
        .dataRdElem (dataRdElem),
        .filtRdElem (filtRdElem),
        .prodValid  (prodValid),
        .prodLast   (prodLast),
        .sumOut     (sumOut),
        .sumValid   (sumValid)
    );

    resultFifo #(
        .fifoDepth(fifoDepth)
    ) u_resultFifo (
        .clkIn    (clkIn),
        .rstIn    (rstIn),
        .sumOut   (sumOut),
        .sumValid (sumValid),
        .readyIn  (readyIn),
        .dataOut  (dataOut),
        .validOut (validOut),
        .fifoRoom (fifoRoom)
    );

endmodule

`default_nettype wire

// ==== rtl/convCtrlPkg.sv ====
`default_nettype none

package convCtrlPkg;

    // Row or column count, 1 to 64
    localparam int dimWidth = 7;

    typedef logic [dimWidth-1:0] dimT;

    // Sequencer states
    typedef enum logic {
        seqIdle,
        seqCalc
    } seqStateT;

endpackage

`default_nettype wire

// ==== rtl/convDataPkg.sv ====
`default_nettype none

package convDataPkg;

    // Matrix element width, shared by both operand stores
    localparam int elemWidth = 16;

    // Full-precision product of two elements
    localparam int prodWidth = 2 * elemWidth;

    // Window sum with guard bits for up to 256 products
    localparam int accWidth = 40;

    typedef logic signed [elemWidth-1:0] elemT;

    typedef logic signed [prodWidth-1:0] prodT;

    // Also the width of the result port
    typedef logic signed [accWidth-1:0] accT;

endpackage

`default_nettype wire

// ==== rtl/convSequencer.sv ====
`default_nettype none

module convSequencer
    import convCtrlPkg::*;
#(
    parameter int addrWidth = 10
) (
    input  logic                 clkIn,
    input  logic                 rstIn,
    input  logic                 startIn,
    input  dimT                  filtRowsIn,
    input  dimT                  filtColsIn,
    input  dimT                  dataRowsIn,
    input  dimT                  dataColsIn,
    input  logic                 fifoRoom,
    output logic [addrWidth-1:0] dataRdAddr,
    output logic [addrWidth-1:0] filtRdAddr,
    output logic                 prodValid,
    output logic                 prodLast
);

    seqStateT state;

    // Loop counters, innermost first
    dimT fcCnt;
    dimT frCnt;
    dimT ocCnt;
    dimT orCnt;

    // Limits and strides captured in idle
    dimT fcMax;
    dimT frMax;
    dimT ocMax;
    dimT orMax;
    dimT filtColsR;
    dimT dataColsR;

    // Counter stage
    dimT                  dataRowS1;
    dimT                  dataColS1;
    logic [addrWidth-1:0] filtRowS1;
    dimT                  filtColS1;
    logic                 validS1;
    logic                 lastS1;

    logic fcDone;
    logic frDone;
    logic ocDone;
    logic orDone;
    logic winEnd;
    logic runEnd;
    logic issue;

    assign fcDone = fcCnt == fcMax;
    assign frDone = frCnt == frMax;
    assign ocDone = ocCnt == ocMax;
    assign orDone = orCnt == orMax;
    assign winEnd = fcDone && frDone;
    assign runEnd = winEnd && ocDone && orDone;

    // Hold only at a window boundary when the FIFO is nearly full
    assign issue = (state == seqCalc) && (!winEnd || fifoRoom);

    always_ff @(posedge clkIn) begin
        if (rstIn) begin
            state     <= seqIdle;
            fcCnt     <= '0;
            frCnt     <= '0;
            ocCnt     <= '0;
            orCnt     <= '0;
            validS1   <= 1'b0;
            prodValid <= 1'b0;
        end else begin
            validS1   <= issue;
            prodValid <= validS1;
            case (state)
                seqIdle: begin
                    if (startIn) begin
                        state <= seqCalc;
                    end
                end
                seqCalc: begin
                    // Counters wrap to zero at the end of the run
                    if (issue) begin
                        fcCnt <= fcDone ? '0 : dimT'(fcCnt + 1'b1);
                        if (fcDone) begin
                            frCnt <= frDone ? '0 : dimT'(frCnt + 1'b1);
                        end
                        if (winEnd) begin
                            ocCnt <= ocDone ? '0 : dimT'(ocCnt + 1'b1);
                        end
                        if (winEnd && ocDone) begin
                            orCnt <= orDone ? '0 : dimT'(orCnt + 1'b1);
                        end
                        if (runEnd) begin
                            state <= seqIdle;
                        end
                    end
                end
                default: state <= seqIdle;
            endcase
        end
    end

    always_ff @(posedge clkIn) begin
        if (state == seqIdle) begin
            fcMax     <= dimT'(filtColsIn - 1'b1);
            frMax     <= dimT'(filtRowsIn - 1'b1);
            ocMax     <= dimT'(dataColsIn - filtColsIn);
            orMax     <= dimT'(dataRowsIn - filtRowsIn);
            filtColsR <= filtColsIn;
            dataColsR <= dataColsIn;
        end

        // Counter stage
        dataRowS1 <= dimT'(orCnt + frCnt);
        dataColS1 <= dimT'(ocCnt + fcCnt);
        filtRowS1 <= addrWidth'(frCnt) * addrWidth'(filtColsR);
        filtColS1 <= fcCnt;
        lastS1    <= winEnd;

        // Address stage, row-major
        dataRdAddr <= addrWidth'(dataRowS1) * addrWidth'(dataColsR) + addrWidth'(dataColS1);
        filtRdAddr <= filtRowS1 + addrWidth'(filtColS1);
        prodLast   <= lastS1;
    end

endmodule

`default_nettype wire

// ==== rtl/macUnit.sv ====
`default_nettype none

module macUnit
    import convDataPkg::*;
(
    input  logic clkIn,
    input  logic rstIn,
    input  elemT dataRdElem,
    input  elemT filtRdElem,
    input  logic prodValid,
    input  logic prodLast,
    output accT  sumOut,
    output logic sumValid
);

    // Tags aligned with the memory read data
    logic validD;
    logic lastD;

    // Product stage
    logic prodValidR;
    logic prodLastR;
    prodT prodR;

    // Sum of the window so far, excluding prodR
    accT accR;

    always_ff @(posedge clkIn) begin
        if (rstIn) begin
            validD     <= 1'b0;
            prodValidR <= 1'b0;
            accR       <= '0;
        end else begin
            validD     <= prodValid;
            prodValidR <= validD;
            // Start a fresh sum once the window is emitted
            if (prodValidR) begin
                accR <= prodLastR ? '0 : sumOut;
            end
        end
    end

    always_ff @(posedge clkIn) begin
        lastD     <= prodLast;
        prodLastR <= lastD;
        prodR     <= dataRdElem * filtRdElem;
    end

    assign sumOut   = accR + accT'(prodR);
    assign sumValid = prodValidR && prodLastR;

endmodule

`default_nettype wire

// ==== rtl/operandStore.sv ====
`default_nettype none

module operandStore
    import convDataPkg::*;
#(
    parameter int addrWidth = 10
) (
    input  logic                 clkIn,
    input  logic                 wrEnIn,
    input  logic [addrWidth:0]   addrIn,
    input  elemT                 wrDataIn,
    input  logic [addrWidth-1:0] dataRdAddr,
    input  logic [addrWidth-1:0] filtRdAddr,
    output elemT                 dataRdElem,
    output elemT                 filtRdElem
);

    localparam int memDepth = 2 ** addrWidth;

    // Registered write port
    logic                 dataWeR;
    logic                 filtWeR;
    logic [addrWidth-1:0] wrAddrR;
    elemT                 wrDataR;

    elemT dataMem [memDepth];
    elemT filtMem [memDepth];

    // Top address bit picks the store: 0 data, 1 filter
    always_ff @(posedge clkIn) begin
        dataWeR <= wrEnIn && !addrIn[addrWidth];
        filtWeR <= wrEnIn && addrIn[addrWidth];
        wrAddrR <= addrIn[addrWidth-1:0];
        wrDataR <= wrDataIn;
    end

    // Data store, one read per cycle
    always_ff @(posedge clkIn) begin
        if (dataWeR) begin
            dataMem[wrAddrR] <= wrDataR;
        end
        dataRdElem <= dataMem[dataRdAddr];
    end

    // Filter store
    always_ff @(posedge clkIn) begin
        if (filtWeR) begin
            filtMem[wrAddrR] <= wrDataR;
        end
        filtRdElem <= filtMem[filtRdAddr];
    end

endmodule

`default_nettype wire

// ==== rtl/resultFifo.sv ====
`default_nettype none

module resultFifo
    import convDataPkg::*;
#(
    parameter int fifoDepth = 16
) (
    input  logic clkIn,
    input  logic rstIn,
    input  accT  sumOut,
    input  logic sumValid,
    input  logic readyIn,
    output accT  dataOut,
    output logic validOut,
    output logic fifoRoom
);

    localparam int ptrWidth = $clog2(fifoDepth);

    // Covers every sum that can still be in the MAC pipeline
    localparam int fifoSlack = 4;
    localparam logic [ptrWidth:0] roomLimit = (ptrWidth + 1)'(fifoDepth - fifoSlack);

    accT                 fifoMem [fifoDepth];
    logic [ptrWidth-1:0] wrPtr;
    logic [ptrWidth-1:0] rdPtr;
    logic [ptrWidth:0]   count;
    logic                popEn;

    assign validOut = count != '0;
    assign popEn    = validOut && readyIn;
    assign dataOut  = fifoMem[rdPtr];
    assign fifoRoom = count < roomLimit;

    always_ff @(posedge clkIn) begin
        if (rstIn) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (sumValid) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (popEn) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({sumValid, popEn})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clkIn) begin
        if (sumValid) begin
            fifoMem[wrPtr] <= sumOut;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/convAccelTb.sv ====
`default_nettype none

module convAccelTb
    import convDataPkg::*, convCtrlPkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int addrWidth = 10;
    localparam int fifoDepth = 16;
    localparam int waitLimit = 20000;

    logic               clkIn;
    logic               rstIn;
    logic               wrEnIn;
    logic [addrWidth:0] addrIn;
    elemT               wrDataIn;
    logic               startIn;
    dimT                filtRowsIn;
    dimT                filtColsIn;
    dimT                dataRowsIn;
    dimT                dataColsIn;
    accT                dataOut;
    logic               validOut;
    logic               readyIn;

    // Copies of what the two stores should hold
    elemT dataModel [2 ** addrWidth];
    elemT filtModel [2 ** addrWidth];

    accT    expQ [$];
    integer seed;
    string  curTest;
    int     accepted;
    int     errors;
    int     testErrBase;
    int     testsRun;
    int     testsFailed;
    logic   randReady;

    convAccelTop #(
        .addrWidth(addrWidth),
        .fifoDepth(fifoDepth)
    ) u_convAccelTop (
        .clkIn      (clkIn),
        .rstIn      (rstIn),
        .wrEnIn     (wrEnIn),
        .addrIn     (addrIn),
        .wrDataIn   (wrDataIn),
        .startIn    (startIn),
        .filtRowsIn (filtRowsIn),
        .filtColsIn (filtColsIn),
        .dataRowsIn (dataRowsIn),
        .dataColsIn (dataColsIn),
        .dataOut    (dataOut),
        .validOut   (validOut),
        .readyIn    (readyIn)
    );

    initial begin
        clkIn = 1'b0;
        forever #50 clkIn = ~clkIn;
    end

    // One output point of the valid-mode correlation
    function automatic accT refPoint(input int r, input int c, input int fRows,
                                     input int fCols, input int dCols);
        longint sum;
        int     fr;
        int     fc;
        sum = 0;
        for (fr = 0; fr < fRows; fr++) begin
            for (fc = 0; fc < fCols; fc++) begin
                sum += longint'(dataModel[(r + fr) * dCols + c + fc])
                    * longint'(filtModel[fr * fCols + fc]);
            end
        end
        return accT'(sum);
    endfunction

    // An entry leaves on the next rising edge, so look in mid-cycle
    always @(negedge clkIn) begin
        if (!rstIn && validOut && readyIn) begin
            if (expQ.size() == 0) begin
                $display("Unexpected result %0d in %s", dataOut, curTest);
                errors++;
            end else begin
                if (dataOut !== expQ[0]) begin
                    $display("Mismatch in %s: expected %0d, actual %0d",
                             curTest, expQ[0], dataOut);
                    errors++;
                end
                void'(expQ.pop_front());
                accepted++;
            end
        end
    end

    task automatic fillModel(input logic toFilt, input int count, input logic extreme);
        int   i;
        elemT value;
        for (i = 0; i < count; i++) begin
            value = extreme ? 16'sh8000 : elemT'($random(seed));
            if (toFilt) begin
                filtModel[i] = value;
            end else begin
                dataModel[i] = value;
            end
        end
    endtask

    task automatic writeStore(input logic toFilt, input int count);
        int i;
        for (i = 0; i < count; i++) begin
            @(posedge clkIn);
            wrEnIn   <= 1'b1;
            addrIn   <= {toFilt, addrWidth'(i)};
            wrDataIn <= toFilt ? filtModel[i] : dataModel[i];
        end
        @(posedge clkIn);
        wrEnIn <= 1'b0;
    endtask

    // Junk on the write port of both stores with the strobe low
    task automatic blockedWrites(input int count);
        int i;
        for (i = 0; i < 2 * count; i++) begin
            @(posedge clkIn);
            wrEnIn   <= 1'b0;
            addrIn   <= {i[0], addrWidth'(i / 2)};
            wrDataIn <= elemT'($random(seed));
        end
    endtask

    task automatic expectQuiet(input int cycles);
        int n;
        for (n = 0; n < cycles; n++) begin
            @(negedge clkIn);
            if (validOut !== 1'b0) begin
                $display("validOut went high in %s, %0d cycles into the idle check",
                         curTest, n);
                errors++;
            end
        end
    endtask

    task automatic runConv(input int fRows, input int fCols, input int dRows, input int dCols);
        int r;
        int c;
        int total;
        int waited;
        for (r = 0; r <= dRows - fRows; r++) begin
            for (c = 0; c <= dCols - fCols; c++) begin
                expQ.push_back(refPoint(r, c, fRows, fCols, dCols));
            end
        end
        total    = expQ.size();
        accepted = 0;
        @(posedge clkIn);
        filtRowsIn <= dimT'(fRows);
        filtColsIn <= dimT'(fCols);
        dataRowsIn <= dimT'(dRows);
        dataColsIn <= dimT'(dCols);
        startIn    <= 1'b1;
        @(posedge clkIn);
        startIn <= 1'b0;
        waited = 0;
        while (accepted < total && waited < waitLimit) begin
            @(posedge clkIn);
            readyIn <= randReady ? 1'($random(seed)) : 1'b1;
            waited++;
        end
        readyIn <= 1'b1;
        if (accepted < total) begin
            $display("Timeout in %s: only %0d of %0d results arrived",
                     curTest, accepted, total);
            errors++;
            expQ.delete();
        end
    endtask

    task automatic beginTest(input string name);
        curTest     = name;
        testErrBase = errors;
        testsRun++;
    endtask

    task automatic endTest();
        if (errors == testErrBase) begin
            $display("Test %s: passed", curTest);
        end else begin
            $display("Test %s: failed with %0d errors", curTest, errors - testErrBase);
            testsFailed++;
        end
    endtask

    initial begin
        seed        = 32'hb3a6;
        errors      = 0;
        testsRun    = 0;
        testsFailed = 0;
        randReady   = 1'b0;
        curTest     = "reset";
        rstIn      <= 1'b1;
        wrEnIn     <= 1'b0;
        addrIn     <= '0;
        wrDataIn   <= '0;
        startIn    <= 1'b0;
        filtRowsIn <= dimT'(1);
        filtColsIn <= dimT'(1);
        dataRowsIn <= dimT'(1);
        dataColsIn <= dimT'(1);
        readyIn    <= 1'b1;
        repeat (4) @(posedge clkIn);
        rstIn <= 1'b0;

        beginTest("idleAfterReset");
        expectQuiet(20);
        endTest();

        beginTest("filter3x3Data8x8");
        fillModel(1'b0, 64, 1'b0);
        fillModel(1'b1, 9, 1'b0);
        writeStore(1'b0, 64);
        writeStore(1'b1, 9);
        runConv(3, 3, 8, 8);
        endTest();

        // Same stores, readyIn toggling at random
        beginTest("backPressure");
        randReady = 1'b1;
        runConv(3, 3, 8, 8);
        randReady = 1'b0;
        expectQuiet(20);
        endTest();

        // One sum per cycle outruns a half-rate reader, so the FIFO fills and stalls
        beginTest("filter1x1");
        fillModel(1'b0, 35, 1'b0);
        fillModel(1'b1, 1, 1'b0);
        writeStore(1'b0, 35);
        writeStore(1'b1, 1);
        randReady = 1'b1;
        runConv(1, 1, 5, 7);
        randReady = 1'b0;
        endTest();

        // 16 products of -32768 squared need more than 32 bits
        beginTest("fullSizeExtreme");
        fillModel(1'b0, 16, 1'b1);
        fillModel(1'b1, 16, 1'b1);
        writeStore(1'b0, 16);
        writeStore(1'b1, 16);
        runConv(4, 4, 4, 4);
        endTest();

        beginTest("filterRewrite");
        fillModel(1'b0, 36, 1'b0);
        fillModel(1'b1, 4, 1'b0);
        writeStore(1'b0, 36);
        writeStore(1'b1, 4);
        runConv(2, 2, 6, 6);
        fillModel(1'b1, 4, 1'b0);
        writeStore(1'b1, 4);
        blockedWrites(36);
        runConv(2, 2, 6, 6);
        endTest();

        $display("Tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
        if (errors == 0 && testsFailed == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
rtl/convDataPkg.sv
rtl/convCtrlPkg.sv
rtl/operandStore.sv
rtl/convSequencer.sv
rtl/macUnit.sv
rtl/resultFifo.sv
rtl/convAccelTop.sv
testbench/convAccelTb.sv
